// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - common/rv_isa_pkg.sv
  - common/rv_pipe_pkg.sv
  - rtl/rv_stage_reg.sv
  - rtl/rv_regfile.sv
  - rtl/rv_result.sv
  - decode/rv_decode.sv
  - decode/rv_hazard.sv
  - execute/rv_execute.sv
  - rtl/rv_core.sv
  - target: simulation
    files:
      - verif/rv_core_tb.sv

// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // Data path width and register index width of RV32I
  localparam int xlen = 32;
  localparam int reg_idx_w = 5;
  localparam int nregs = 1 << reg_idx_w;

  // Shifts only use the low bits of the second operand
  localparam int shamt_w = $clog2(xlen);

  // Bit positions of the fixed instruction fields
  localparam int op_w = 7;
  localparam int rd_lsb = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb = 15;
  localparam int rs2_lsb = 20;
  localparam int funct7_lsb = 25;

  // The I-type immediate is the top 12 bits and is sign extended
  localparam int imm_i_lsb = 20;
  localparam int imm_i_w = 12;
  // The U-type immediate is the top 20 bits placed above 12 zero bits
  localparam int imm_u_lsb = 12;
  localparam int imm_u_w = 20;

  // Major opcodes handled by the pipeline
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_lui = 7'b0110111;

  // funct3 values shared by the register and immediate groups
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct7 pattern that selects SUB over ADD and SRA over SRL
  localparam logic [6:0] funct7_alt = 7'b0100000;

endpackage

// ==== common/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

  import rv_isa_pkg::*;

  // One code per ALU function, pass_b covers LUI and NOPs
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // Decoded instruction as it leaves decode and sits in the ID/EX register
  typedef struct packed {
    alu_op_e              alu_op;
    logic [reg_idx_w-1:0] rd;
    logic [reg_idx_w-1:0] rs1_idx;
    logic [reg_idx_w-1:0] rs2_idx;
    logic                 rs1_used;
    logic                 rs2_used;
    // Second operand comes from imm instead of rs2_val
    logic                 use_imm;
    logic [xlen-1:0]      imm;
    logic [xlen-1:0]      rs1_val;
    logic [xlen-1:0]      rs2_val;
    // Set only for a nonzero rd of a writing instruction
    logic                 reg_write;
  } dec_t;

  // Executed result held in the EX/RES register
  typedef struct packed {
    logic [reg_idx_w-1:0] rd;
    logic [xlen-1:0]      value;
    logic                 reg_write;
  } res_t;

endpackage

// ==== decode/rv_decode.sv ====
module rv_decode
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [xlen-1:0]      in_instr,
  input  logic                 id_hold,
  input  logic                 pipe_hold,
  output logic [reg_idx_w-1:0] rf_raddr1,
  output logic [reg_idx_w-1:0] rf_raddr2,
  input  logic [xlen-1:0]      rf_rdata1,
  input  logic [xlen-1:0]      rf_rdata2,
  output logic                 dec_valid,
  output dec_t                 dec,
  output logic [reg_idx_w-1:0] rs1_id,
  output logic [reg_idx_w-1:0] rs2_id,
  output logic                 rs1_used,
  output logic                 rs2_used
);

  logic [xlen-1:0] instr_q;
  logic [op_w-1:0] opcode;
  logic [2:0]      funct3;
  logic            alt;

  // Maps funct3 onto the ALU, alt picks SUB or SRA where it applies
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt_sel);
    alu_op_e op;
    unique case (f3)
      f3_add_sub: op = alt_sel ? alu_sub : alu_add;
      f3_sll:     op = alu_sll;
      f3_slt:     op = alu_slt;
      f3_sltu:    op = alu_sltu;
      f3_xor:     op = alu_xor;
      f3_srl_sra: op = alt_sel ? alu_sra : alu_srl;
      f3_or:      op = alu_or;
      default:    op = alu_and;
    endcase
    return op;
  endfunction

  // A new word is taken whenever the current one can move on to ID/EX
  assign in_ready = !(id_hold || pipe_hold);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (in_ready) begin
      dec_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready && in_valid) begin
      instr_q <= in_instr;
    end
  end

  assign opcode = instr_q[op_w-1:0];
  assign funct3 = instr_q[funct3_lsb +: 3];
  assign alt    = (instr_q[funct7_lsb +: 7] == funct7_alt);

  // Register file is read every cycle, so a held instruction sees fresh values
  assign rf_raddr1 = instr_q[rs1_lsb +: reg_idx_w];
  assign rf_raddr2 = instr_q[rs2_lsb +: reg_idx_w];

  always_comb begin
    dec          = '0;
    dec.alu_op   = alu_pass_b;
    dec.rd       = instr_q[rd_lsb +: reg_idx_w];
    dec.rs1_idx  = rf_raddr1;
    dec.rs2_idx  = rf_raddr2;
    dec.rs1_val  = rf_rdata1;
    dec.rs2_val  = rf_rdata2;
    unique case (opcode)
      op_reg: begin
        dec.alu_op    = alu_from_f3(funct3, alt);
        dec.rs1_used  = 1'b1;
        dec.rs2_used  = 1'b1;
        dec.reg_write = 1'b1;
      end
      op_imm: begin
        // In ADDI and friends the funct7 bits are immediate, not a modifier
        dec.alu_op    = alu_from_f3(funct3, alt && (funct3 == f3_srl_sra));
        dec.rs1_used  = 1'b1;
        dec.use_imm   = 1'b1;
        dec.imm       = {{(xlen-imm_i_w){instr_q[xlen-1]}}, instr_q[imm_i_lsb +: imm_i_w]};
        dec.reg_write = 1'b1;
      end
      op_lui: begin
        dec.use_imm   = 1'b1;
        dec.imm       = {instr_q[imm_u_lsb +: imm_u_w], {imm_u_lsb{1'b0}}};
        dec.reg_write = 1'b1;
      end
      default: begin
        // Unsupported words pass a zero immediate to x0
        dec.rd      = '0;
        dec.use_imm = 1'b1;
      end
    endcase
    // Writes to x0 never reach the register file or the hazard checks
    dec.reg_write = dec.reg_write && (dec.rd != '0);
  end

  // An empty decode stage must not raise a false hazard
  assign rs1_id   = dec.rs1_idx;
  assign rs2_id   = dec.rs2_idx;
  assign rs1_used = dec_valid && dec.rs1_used;
  assign rs2_used = dec_valid && dec.rs2_used;

  // The source keeps its word steady until decode accepts it
  a_in_stable: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> $stable(in_instr));

endmodule

// ==== decode/rv_hazard.sv ====
module rv_hazard
  import rv_isa_pkg::*;
#(
  parameter int FWD         = 0,
  parameter int FWD_REGFILE = 1
) (
  input  logic [reg_idx_w-1:0] rs1_id,
  input  logic [reg_idx_w-1:0] rs2_id,
  input  logic                 rs1_used,
  input  logic                 rs2_used,
  input  logic [reg_idx_w-1:0] rd_ex,
  input  logic                 reg_write_ex,
  input  logic [reg_idx_w-1:0] rd_res,
  input  logic                 reg_write_res,
  output logic                 id_hold,
  output logic                 ex_bubble
);

  logic ex_match;
  logic res_match;
  logic ex_stall;
  logic res_stall;
  logic data_hazard;

  // reg_write is already clear for x0 and for empty stages,
  // so an index match with reg_write set is a real RAW dependency
  assign ex_match  = reg_write_ex &&
                     ((rs1_used && (rd_ex == rs1_id)) || (rs2_used && (rd_ex == rs2_id)));
  assign res_match = reg_write_res &&
                     ((rs1_used && (rd_res == rs1_id)) || (rs2_used && (rd_res == rs2_id)));

  if (FWD != 0) begin : g_ex_fwd
    // The producer reaches EX/RES when the consumer reaches EX,
    // and execute picks the value up from there
    assign ex_stall = 1'b0;
  end else begin : g_ex_stall
    // Wait until the producer has left EX
    assign ex_stall = ex_match;
  end

  if (FWD_REGFILE != 0) begin : g_res_bypass
    // The result commits on the same edge the consumer leaves decode,
    // and the register file passes the write data straight to the read port
    assign res_stall = 1'b0;
  end else begin : g_res_stall
    // Wait until the write has landed in the array
    assign res_stall = res_match;
  end

  assign data_hazard = ex_stall || res_stall;

  // Keep the consumer in decode and send an empty slot down to EX instead
  assign id_hold   = data_hazard;
  assign ex_bubble = data_hazard;

  // A writer aimed at x0 would raise hazards on reads that always give zero
  a_no_x0_writer: assert final ((!reg_write_ex || (rd_ex != '0)) &&
                                (!reg_write_res || (rd_res != '0)));

endmodule

// ==== execute/rv_execute.sv ====
module rv_execute
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
#(
  parameter int FWD = 0
) (
  input  dec_t                 ex,
  input  logic [reg_idx_w-1:0] fwd_rd,
  input  logic                 fwd_reg_write,
  input  logic [xlen-1:0]      fwd_value,
  output res_t                 res
);

  localparam bit fwd_on = (FWD != 0);

  logic                fwd_a;
  logic                fwd_b;
  logic [xlen-1:0]     rs1_v;
  logic [xlen-1:0]     rs2_v;
  logic [xlen-1:0]     op_a;
  logic [xlen-1:0]     op_b;
  logic [shamt_w-1:0]  shamt;
  logic [xlen-1:0]     value;

  // The result stage holds the newest value of its rd, which makes it
  // take precedence over what the register file gave in decode
  assign fwd_a = fwd_on && ex.rs1_used && fwd_reg_write && (fwd_rd == ex.rs1_idx);
  assign fwd_b = fwd_on && ex.rs2_used && fwd_reg_write && (fwd_rd == ex.rs2_idx);

  assign rs1_v = fwd_a ? fwd_value : ex.rs1_val;
  assign rs2_v = fwd_b ? fwd_value : ex.rs2_val;

  // Immediate forms replace the second register operand
  assign op_a  = rs1_v;
  assign op_b  = ex.use_imm ? ex.imm : rs2_v;
  assign shamt = op_b[shamt_w-1:0];

  always_comb begin
    unique case (ex.alu_op)
      alu_add:  value = op_a + op_b;
      alu_sub:  value = op_a - op_b;
      alu_sll:  value = op_a << shamt;
      alu_slt:  value = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: value = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:  value = op_a ^ op_b;
      alu_srl:  value = op_a >> shamt;
      // Arithmetic shift copies the sign bit in from the top
      alu_sra:  value = $unsigned($signed(op_a) >>> shamt);
      alu_or:   value = op_a | op_b;
      alu_and:  value = op_a & op_b;
      // LUI and NOPs just pass the immediate through
      default:  value = op_b;
    endcase
  end

  // rd and reg_write ride along unchanged
  always_comb begin
    res           = '0;
    res.rd        = ex.rd;
    res.value     = value;
    res.reg_write = ex.reg_write;
  end

endmodule

// ==== rtl/rv_core.sv ====
module rv_core
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
#(
  parameter int FWD         = 0,
  parameter int FWD_REGFILE = 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [xlen-1:0]      in_instr,
  output logic                 res_valid,
  input  logic                 res_ready,
  output logic [reg_idx_w-1:0] res_rd,
  output logic [xlen-1:0]      res_value
);

  logic [reg_idx_w-1:0] rf_raddr1;
  logic [reg_idx_w-1:0] rf_raddr2;
  logic [xlen-1:0]      rf_rdata1;
  logic [xlen-1:0]      rf_rdata2;
  logic                 rf_we;
  logic [reg_idx_w-1:0] rf_waddr;
  logic [xlen-1:0]      rf_wdata;

  logic                 dec_valid;
  dec_t                 dec;
  logic [reg_idx_w-1:0] rs1_id;
  logic [reg_idx_w-1:0] rs2_id;
  logic                 rs1_used;
  logic                 rs2_used;
  logic                 id_hold;
  logic                 ex_bubble;
  logic                 pipe_hold;

  logic                 ex_valid;
  dec_t                 ex_q;
  res_t                 ex_res;
  logic                 res_stage_valid;
  res_t                 res_q;
  logic                 reg_write_ex;
  logic                 reg_write_res;

  // Empty stages never count as writers
  assign reg_write_ex  = ex_valid && ex_q.reg_write;
  assign reg_write_res = res_stage_valid && res_q.reg_write;

  rv_decode rv_decode_i (
    .clk, .rst_n, .in_valid, .in_ready, .in_instr, .id_hold, .pipe_hold,
    .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
    .dec_valid, .dec, .rs1_id, .rs2_id, .rs1_used, .rs2_used
  );

  rv_regfile #(.FWD_REGFILE(FWD_REGFILE)) rv_regfile_i (
    .clk, .rst_n, .raddr1(rf_raddr1), .raddr2(rf_raddr2), .rdata1(rf_rdata1),
    .rdata2(rf_rdata2), .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
  );

  rv_hazard #(.FWD(FWD), .FWD_REGFILE(FWD_REGFILE)) rv_hazard_i (
    .rs1_id, .rs2_id, .rs1_used, .rs2_used,
    .rd_ex(ex_q.rd), .reg_write_ex, .rd_res(res_q.rd), .reg_write_res,
    .id_hold, .ex_bubble
  );

  // ID/EX takes a bubble while decode waits on a hazard
  rv_stage_reg #(.payload_t(dec_t)) id_ex_i (
    .clk, .rst_n, .in_valid(dec_valid), .in_data(dec), .hold(pipe_hold),
    .bubble(ex_bubble), .out_valid(ex_valid), .out_data(ex_q)
  );

  // Forwarding source is the EX/RES register
  rv_execute #(.FWD(FWD)) rv_execute_i (
    .ex(ex_q), .fwd_rd(res_q.rd), .fwd_reg_write(reg_write_res),
    .fwd_value(res_q.value), .res(ex_res)
  );

  // Nothing is ever squashed past execute
  rv_stage_reg #(.payload_t(res_t)) ex_res_i (
    .clk, .rst_n, .in_valid(ex_valid), .in_data(ex_res), .hold(pipe_hold),
    .bubble(1'b0), .out_valid(res_stage_valid), .out_data(res_q)
  );

  rv_result rv_result_i (
    .clk, .rst_n, .res_in_valid(res_stage_valid), .res_in(res_q),
    .res_valid, .res_ready, .res_rd, .res_value, .pipe_hold,
    .rf_we, .rf_waddr, .rf_wdata
  );

endmodule

// ==== rtl/rv_regfile.sv ====
module rv_regfile
  import rv_isa_pkg::*;
#(
  parameter int FWD_REGFILE = 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [reg_idx_w-1:0] raddr1,
  input  logic [reg_idx_w-1:0] raddr2,
  output logic [xlen-1:0]      rdata1,
  output logic [xlen-1:0]      rdata2,
  input  logic                 we,
  input  logic [reg_idx_w-1:0] waddr,
  input  logic [xlen-1:0]      wdata
);

  localparam bit bypass_on = (FWD_REGFILE != 0);

  logic [xlen-1:0] regs [nregs];
  logic            bypass1;
  logic            bypass2;

  // x0 is cleared at reset and never written, so it reads zero for good
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Write-through lets a reader see the value committed on this same edge
  assign bypass1 = bypass_on && we && (waddr != '0) && (waddr == raddr1);
  assign bypass2 = bypass_on && we && (waddr != '0) && (waddr == raddr2);

  assign rdata1 = bypass1 ? wdata : regs[raddr1];
  assign rdata2 = bypass2 ? wdata : regs[raddr2];

  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    ((raddr1 == '0) |-> (rdata1 == '0)) and ((raddr2 == '0) |-> (rdata2 == '0)));

endmodule

// ==== rtl/rv_result.sv ====
module rv_result
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 res_in_valid,
  input  res_t                 res_in,
  output logic                 res_valid,
  input  logic                 res_ready,
  output logic [reg_idx_w-1:0] res_rd,
  output logic [xlen-1:0]      res_value,
  output logic                 pipe_hold,
  output logic                 rf_we,
  output logic [reg_idx_w-1:0] rf_waddr,
  output logic [xlen-1:0]      rf_wdata
);

  // The EX/RES register content is the output beat itself
  assign res_valid = res_in_valid;
  assign res_rd    = res_in.rd;
  assign res_value = res_in.value;

  // A stalled beat freezes the whole pipe behind it
  assign pipe_hold = res_valid && !res_ready;

  // Commit only on the transfer so a held beat is written exactly once
  assign rf_we    = res_valid && res_ready && res_in.reg_write;
  assign rf_waddr = res_in.rd;
  assign rf_wdata = res_in.value;

  // Back-pressure must keep the same beat on the output until it goes
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && !res_ready |=> res_valid && $stable(res_rd) && $stable(res_value));

endmodule

// ==== rtl/rv_stage_reg.sv ====
module rv_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  input  logic     hold,
  input  logic     bubble,
  output logic     out_valid,
  output payload_t out_data
);

  // The valid bit is the only control state of a stage
  // Hold freezes the stage, so it wins over a bubble request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (!hold) begin
      out_valid <= in_valid && !bubble;
    end
  end

  // Payload only matters while out_valid is set
  // It is skipped on a bubble and whenever the source has nothing valid
  always_ff @(posedge clk) begin
    if (!hold && !bubble && in_valid) begin
      out_data <= in_data;
    end
  end

endmodule

// ==== sources.f ====
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
rtl/rv_stage_reg.sv
rtl/rv_regfile.sv
rtl/rv_result.sv
decode/rv_decode.sv
decode/rv_hazard.sv
execute/rv_execute.sv
rtl/rv_core.sv
verif/rv_core_tb.sv

// ==== verif/rv_core_tb.sv ====
module rv_core_tb;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  logic [31:0] in_instr;
  logic        res_valid;
  logic        res_ready;
  logic [4:0]  res_rd;
  logic [31:0] res_value;

  // Architectural register state of the reference model
  logic [31:0] model_regs [32];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_val [$];

  // Per-test knobs and counters shared by the stimulus tasks
  int          test_n;
  int          test_mode;
  int          valid_pct;
  int          ready_pct;
  int          issued;
  int          accepted;
  int          results;
  int          cycles;
  int          errors;
  int          checks;
  int          tests_run;
  bit          in_free;
  bit          timed_out;
  logic [4:0]  prev_rd;

  rv_core #(.FWD(1), .FWD_REGFILE(1)) rv_core_i (
    .clk, .rst_n, .in_valid, .in_ready, .in_instr,
    .res_valid, .res_ready, .res_rd, .res_value
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic alt,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [11:0] imm,
                                        input logic [4:0] rd, input logic [4:0] rs1);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  // Random R-type or I-type ALU word, r_only keeps rs2 meaningful
  function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input bit r_only);
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    f3  = 3'($urandom_range(0, 7));
    alt = 1'($urandom_range(0, 1));
    imm = 12'($urandom);
    if (r_only || $urandom_range(0, 1) == 0) begin
      // Only ADD/SUB and SRL/SRA have an alternate funct7
      if (f3 != 3'b000 && f3 != 3'b101) alt = 1'b0;
      return enc_r(f3, alt, rd, rs1, rs2);
    end
    // Shift immediates keep their funct7 bits legal
    if (f3 == 3'b001) imm[11:5] = 7'b0000000;
    if (f3 == 3'b101) imm[11:5] = alt ? 7'b0100000 : 7'b0000000;
    return enc_i(f3, imm, rd, rs1);
  endfunction

  // Next instruction word for the current test mode
  function automatic logic [31:0] gen_instr();
    logic [31:0] instr;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    rd  = 5'($urandom_range(0, 7));
    rs1 = 5'($urandom_range(0, 7));
    rs2 = 5'($urandom_range(0, 7));
    case (test_mode)
      0: begin
        rd = 5'($urandom);
        if ($urandom_range(0, 9) == 0) instr = {20'($urandom), rd, 7'b0110111};
        else instr = rand_alu(rd, 5'($urandom_range(0, 15)), 5'($urandom_range(0, 15)), 0);
      end
      1: begin
        // Every word reads the previous destination through rs1 or rs2
        rd = 5'($urandom_range(1, 7));
        if ($urandom_range(0, 1) == 0) instr = rand_alu(rd, prev_rd, rs2, 0);
        else instr = rand_alu(rd, rs1, prev_rd, 1);
      end
      2: instr = rand_alu(rd, rs1, rs2, 0);
      default: begin
        f3 = 3'($urandom_range(2, 3));
        case ($urandom_range(0, 3))
          0: instr = {20'($urandom), rd, 7'b0110111};
          1: instr = enc_i($urandom_range(0, 1) ? 3'b001 : 3'b101,
                           {$urandom_range(0, 1) ? 7'b0100000 : 7'b0000000,
                            5'($urandom_range(16, 31))}, rd, rs1);
          2: instr = $urandom_range(0, 1) ? enc_r(f3, 1'b0, rd, rs1, rs2)
                                          : enc_i(f3, 12'($urandom), rd, rs1);
          default: begin
            // Loads, stores, branches and jumps are outside the pipeline
            instr = $urandom;
            case ($urandom_range(0, 3))
              0: instr[6:0] = 7'b0000011;
              1: instr[6:0] = 7'b0100011;
              2: instr[6:0] = 7'b1100011;
              default: instr[6:0] = 7'b1101111;
            endcase
          end
        endcase
      end
    endcase
    prev_rd = instr[11:7];
    return instr;
  endfunction

  // Executes one accepted word on the architectural model
  function automatic void model_exec(input logic [31:0] instr, output logic [4:0] rd,
                                     output logic [31:0] value);
    logic [6:0]  opc;
    logic [31:0] a;
    logic [31:0] b;
    opc   = instr[6:0];
    rd    = instr[11:7];
    a     = model_regs[instr[19:15]];
    b     = model_regs[instr[24:20]];
    value = '0;
    if (opc == 7'b0110011 || opc == 7'b0010011) begin
      if (opc == 7'b0010011) b = {{20{instr[31]}}, instr[31:20]};
      case (instr[14:12])
        3'b000: value = (instr[30] && opc == 7'b0110011) ? a - b : a + b;
        3'b001: value = a << b[4:0];
        3'b010: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: value = (a < b) ? 32'd1 : 32'd0;
        3'b100: value = a ^ b;
        3'b101: begin
          // Bit 30 picks the arithmetic shift that copies the sign bit
          if (instr[30]) value = $signed(a) >>> b[4:0];
          else value = a >> b[4:0];
        end
        3'b110: value = a | b;
        default: value = a & b;
      endcase
    end else if (opc == 7'b0110111) begin
      value = {instr[31:12], 12'b0};
    end else begin
      rd = '0;
    end
    if (rd != '0) model_regs[rd] = value;
  endfunction

  // One clock: drive on the falling edge, then sample the settled handshakes
  task automatic step_cycle();
    logic [4:0]  m_rd;
    logic [31:0] m_val;
    @(negedge clk);
    if (in_free) begin
      if (issued < test_n && $urandom_range(1, 100) <= valid_pct) begin
        in_instr = gen_instr();
        in_valid = 1'b1;
        in_free  = 1'b0;
        issued++;
      end else begin
        in_valid = 1'b0;
      end
    end
    res_ready = ($urandom_range(1, 100) <= ready_pct);
    #1;
    if (in_valid && in_ready) begin
      model_exec(in_instr, m_rd, m_val);
      exp_rd.push_back(m_rd);
      exp_val.push_back(m_val);
      accepted++;
      in_free = 1'b1;
    end
    if (res_valid && res_ready) begin
      results++;
      checks++;
      assert (exp_rd.size() > 0) else begin
        $display("A result came out with no instruction outstanding at time %0t", $time);
        errors++;
      end
      if (exp_rd.size() > 0) begin
        m_rd  = exp_rd.pop_front();
        m_val = exp_val.pop_front();
        assert (res_rd == m_rd && res_value == m_val) else begin
          $display("error %0t: got rd %0d value %h, expected rd %0d value %h",
                   $time, res_rd, res_value, m_rd, m_val);
          errors++;
        end
      end
    end
    cycles++;
  endtask

  task automatic run_test(input string name, input int n, input int mode,
                          input int v_pct, input int r_pct);
    int limit;
    int err_start;
    test_n    = n;
    test_mode = mode;
    valid_pct = v_pct;
    ready_pct = r_pct;
    issued    = 0;
    accepted  = 0;
    results   = 0;
    cycles    = 0;
    err_start = errors;
    limit     = 10 * n + 100;
    while (!(accepted == n && exp_rd.size() == 0)) begin
      if (cycles >= limit) begin
        $display("Timeout: test %s did not finish within %0d cycles", name, limit);
        timed_out = 1'b1;
        break;
      end
      step_cycle();
    end
    if (!timed_out) begin
      // A few idle cycles catch duplicated beats
      repeat (4) step_cycle();
      checks++;
      assert (results == accepted) else begin
        $display("Test %s saw %0d results for %0d accepted instructions",
                 name, results, accepted);
        errors++;
      end
      $display("test %s: %0d accepted, %0d results, %0d errors",
               name, accepted, results, errors - err_start);
    end
    tests_run++;
  endtask

  initial begin
    void'($urandom(32'h2537664b));
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_instr  = '0;
    res_ready = 1'b0;
    in_free   = 1'b1;
    timed_out = 1'b0;
    prev_rd   = '0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    assert (in_ready && !res_valid) else begin
      $display("The pipeline is not idle after reset");
      errors++;
    end
    run_test("random_alu", 200, 0, 70, 100);
    if (!timed_out) run_test("dependent_chain", 150, 1, 100, 100);
    if (!timed_out) run_test("back_pressure", 200, 2, 80, 50);
    if (!timed_out) run_test("corner_cases", 150, 3, 90, 80);
    $display("tests %0d, checks %0d, errors %0d, timeout %0d",
             tests_run, checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
